/* rtl/regReadPkg.sv */
// Shared definitions for the register-read stage
//   widths and counts
//   physical tag, opcode enum
//   issue, bypass, execute, unmap and branch-resolve packets
`default_nettype none

package regReadPkg;

  localparam int NumLanes       = 2;   // Issue and write-back lanes
  localparam int NumPhysRegs    = 32;
  localparam int PhysRegW       = 5;
  localparam int NumArchRegs    = 16;  // Ready after reset
  localparam int DataW          = 32;
  localparam int NumCheckpoints = 4;
  localparam int CheckpointW    = 2;
  localparam int ImmW           = 16;
  localparam int PcW            = 32;

  typedef logic [PhysRegW-1:0] physTag_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    LOAD,
    STORE,
    BRANCH
  } opcode_t;

  typedef struct packed {
    logic [NumCheckpoints-1:0] branchMask;  // One bit per open branch
    physTag_t                  src1;
    physTag_t                  src2;
    physTag_t                  dest;
    opcode_t                   opcode;
    logic [ImmW-1:0]           imm;
    logic [PcW-1:0]            pc;
  } issuePkt_t;

  typedef struct packed {
    physTag_t         dest;
    logic [DataW-1:0] data;
  } bypassPkt_t;

  typedef struct packed {
    logic [DataW-1:0] src1Data;
    logic [DataW-1:0] src2Data;
    issuePkt_t        issue;  // Carried through as issued
  } execPkt_t;

  typedef struct packed {
    logic     valid;
    physTag_t tag;
  } unmapReq_t;

  typedef struct packed {
    logic                   verified;
    logic                   mispredict;
    logic [CheckpointW-1:0] checkpointId;
  } ctrlResolve_t;

endpackage

`default_nettype wire

/* rtl/physRegFile.sv */
// Physical register file
//   2 read ports per lane, combinational
//   1 write port per lane, written at the clock edge
//   writes held off during recovery
`timescale 1ns/10ps
`default_nettype none

module physRegFile (
  input  wire                         clk,
  input  wire regReadPkg::physTag_t   rdTag_i [2*regReadPkg::NumLanes],
  output logic [regReadPkg::DataW-1:0] rdData_o [2*regReadPkg::NumLanes],
  input  wire regReadPkg::bypassPkt_t wrPkt_i [regReadPkg::NumLanes],
  input  wire [regReadPkg::NumLanes-1:0] wrValid_i,
  input  wire                         recover_i
);
  import regReadPkg::*;

  logic [DataW-1:0]    mem [NumPhysRegs];
  logic [NumLanes-1:0] wrEn;

  // Write-back is dropped while the core recovers
  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      wrEn[l] = wrValid_i[l] & ~recover_i;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < NumLanes; l++) begin
      if (wrEn[l]) begin
        mem[wrPkt_i[l].dest] <= wrPkt_i[l].data;
      end
    end
  end

  always_comb begin
    for (int r = 0; r < 2*NumLanes; r++) begin
      rdData_o[r] = mem[rdTag_i[r]];  // Stored value without forwarding
    end
  end

endmodule

`default_nettype wire

/* rtl/operandLane.sv */
// One issue lane of the register-read stage
//   bypass match vectors for both sources
//   one-hot forward select, file data otherwise
//   squash on a verified mispredict
//   execute packet assembly
`timescale 1ns/10ps
`default_nettype none

module operandLane (
  input  wire regReadPkg::issuePkt_t    issuePkt_i,
  input  wire                           issueValid_i,
  input  wire [regReadPkg::DataW-1:0]   fileData_i [2],
  input  wire regReadPkg::bypassPkt_t   bypassPkt_i [regReadPkg::NumLanes],
  input  wire [regReadPkg::NumLanes-1:0] bypassValid_i,
  input  wire regReadPkg::ctrlResolve_t ctrlResolve_i,
  output regReadPkg::execPkt_t          execPkt_o,
  output logic                          execValid_o
);
  import regReadPkg::*;

  physTag_t            srcTag [2];
  logic [NumLanes-1:0] matchVec [2];
  logic [DataW-1:0]    opData [2];
  logic                squashHit;

  assign srcTag[0] = issuePkt_i.src1;
  assign srcTag[1] = issuePkt_i.src2;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      for (int l = 0; l < NumLanes; l++) begin
        matchVec[s][l] = bypassValid_i[l] && (bypassPkt_i[l].dest == srcTag[s]);
      end
    end
  end

  // Forward only on a single hit; none or several fall back to the file
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      opData[s] = fileData_i[s];
      for (int l = 0; l < NumLanes; l++) begin
        if (matchVec[s] == (NumLanes'(1) << l)) begin
          opData[s] = bypassPkt_i[l].data;
        end
      end
    end
  end

  assign squashHit = ctrlResolve_i.verified & ctrlResolve_i.mispredict &
                     issuePkt_i.branchMask[ctrlResolve_i.checkpointId];

  assign execValid_o = issueValid_i & ~squashHit;  // Younger than the bad branch

  always_comb begin
    execPkt_o.src1Data = opData[0];
    execPkt_o.src2Data = opData[1];
    execPkt_o.issue    = issuePkt_i;
  end

endmodule

`default_nettype wire

/* rtl/readyTable.sv */
// Physical register ready table
//   architectural pattern on reset or exception
//   unmap clears, wakeup sets
//   wakeup wins over unmap of the same tag
`timescale 1ns/10ps
`default_nettype none

module readyTable (
  input  wire                              clk,
  input  wire                              rstN_i,
  input  wire                              exception_i,
  input  wire regReadPkg::unmapReq_t       unmap_i [regReadPkg::NumLanes],
  input  wire regReadPkg::physTag_t        wakeTag_i [regReadPkg::NumLanes],
  input  wire [regReadPkg::NumLanes-1:0]   wakeValid_i,
  output logic [regReadPkg::NumPhysRegs-1:0] rdy_o
);
  import regReadPkg::*;

  logic [NumPhysRegs-1:0] rdyQ;
  logic [NumPhysRegs-1:0] rdyNext;
  logic [NumPhysRegs-1:0] archPattern;

  always_comb begin
    for (int i = 0; i < NumPhysRegs; i++) begin
      archPattern[i] = (i < NumArchRegs);  // Mapped registers hold committed values
    end
  end

  always_comb begin
    rdyNext = rdyQ;
    for (int l = 0; l < NumLanes; l++) begin
      if (unmap_i[l].valid) begin
        rdyNext[unmap_i[l].tag] = 1'b0;
      end
    end
    // Sets applied last
    for (int l = 0; l < NumLanes; l++) begin
      if (wakeValid_i[l]) begin
        rdyNext[wakeTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i || exception_i) begin
      rdyQ <= archPattern;
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign rdy_o = rdyQ;

endmodule

`default_nettype wire

/* rtl/regRead.sv */
// Register-read stage, top level
//   physical register file shared by all lanes
//   ready table
//   one operand lane per issue lane
`timescale 1ns/10ps
`default_nettype none

module regRead (
  input  wire                                clk,
  input  wire                                rstN_i,
  input  wire regReadPkg::issuePkt_t         issuePkt_i [regReadPkg::NumLanes],
  input  wire [regReadPkg::NumLanes-1:0]     issueValid_i,
  input  wire regReadPkg::bypassPkt_t        bypassPkt_i [regReadPkg::NumLanes],
  input  wire [regReadPkg::NumLanes-1:0]     bypassValid_i,
  input  wire regReadPkg::unmapReq_t         unmap_i [regReadPkg::NumLanes],
  input  wire regReadPkg::physTag_t          wakeTag_i [regReadPkg::NumLanes],
  input  wire [regReadPkg::NumLanes-1:0]     wakeValid_i,
  input  wire regReadPkg::ctrlResolve_t      ctrlResolve_i,
  input  wire                                recover_i,
  input  wire                                exception_i,
  output regReadPkg::execPkt_t               execPkt_o [regReadPkg::NumLanes],
  output logic [regReadPkg::NumLanes-1:0]    execValid_o,
  output logic [regReadPkg::NumPhysRegs-1:0] physRegRdy_o
);
  import regReadPkg::*;

  physTag_t         rdTag [2*NumLanes];
  logic [DataW-1:0] rdData [2*NumLanes];

  physRegFile physRegFile_i (
    .clk       (clk),
    .rdTag_i   (rdTag),
    .rdData_o  (rdData),
    .wrPkt_i   (bypassPkt_i),
    .wrValid_i (bypassValid_i),
    .recover_i (recover_i)
  );

  readyTable readyTable_i (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .exception_i (exception_i),
    .unmap_i     (unmap_i),
    .wakeTag_i   (wakeTag_i),
    .wakeValid_i (wakeValid_i),
    .rdy_o       (physRegRdy_o)
  );

  for (genvar l = 0; l < NumLanes; l++) begin : genLane
    logic [DataW-1:0] laneData [2];

    // Read ports 2l and 2l+1 belong to lane l
    assign rdTag[2*l]   = issuePkt_i[l].src1;
    assign rdTag[2*l+1] = issuePkt_i[l].src2;
    assign laneData[0]  = rdData[2*l];
    assign laneData[1]  = rdData[2*l+1];

    operandLane operandLane_i (
      .issuePkt_i    (issuePkt_i[l]),
      .issueValid_i  (issueValid_i[l]),
      .fileData_i    (laneData),
      .bypassPkt_i   (bypassPkt_i),
      .bypassValid_i (bypassValid_i),
      .ctrlResolve_i (ctrlResolve_i),
      .execPkt_o     (execPkt_o[l]),
      .execValid_o   (execValid_o[l])
    );
  end

endmodule

`default_nettype wire

/* bench/regReadModel.svh */
// Reference model of the register-read stage
//   shadow register file with written flags
//   shadow ready table
//   expected operand, valid and ready bits
`ifndef REGREADMODEL_SVH
`define REGREADMODEL_SVH

logic [DataW-1:0]       shadowMem [NumPhysRegs];
bit                     written [NumPhysRegs];
logic [NumPhysRegs-1:0] shadowRdy;

function automatic logic [NumPhysRegs-1:0] archReady();
  return NumPhysRegs'((64'd1 << NumArchRegs) - 64'd1);  // Low tags ready
endfunction

// Expected operand by the bypass rule with the shadow as fallback; 0 back if unknown
function automatic bit forwardedOrStored(input physTag_t tag, input bypassPkt_t byp [NumLanes],
                                         input logic [NumLanes-1:0] bv,
                                         output logic [DataW-1:0] data);
  int hits;
  hits = 0;
  data = shadowMem[tag];
  for (int l = 0; l < NumLanes; l++) begin
    if (bv[l] && byp[l].dest == tag) begin
      hits++;
    end
  end
  if (hits == 1) begin
    for (int l = 0; l < NumLanes; l++) begin
      if (bv[l] && byp[l].dest == tag) begin
        data = byp[l].data;
      end
    end
    return 1'b1;
  end
  return written[tag];
endfunction

function automatic logic survivesSquash(input logic valid, input logic [NumCheckpoints-1:0] mask,
                                        input ctrlResolve_t ctrl);
  return valid && !(ctrl.verified && ctrl.mispredict && mask[ctrl.checkpointId]);
endfunction

function automatic logic [NumPhysRegs-1:0] nextReady(
    input logic [NumPhysRegs-1:0] cur, input logic inReset, input logic exc,
    input unmapReq_t un [NumLanes], input physTag_t wTag [NumLanes],
    input logic [NumLanes-1:0] wValid);
  logic [NumPhysRegs-1:0] n;
  if (inReset || exc) begin
    return archReady();
  end
  n = cur;
  for (int l = 0; l < NumLanes; l++) begin
    if (un[l].valid) begin
      n[un[l].tag] = 1'b0;
    end
  end
  for (int l = 0; l < NumLanes; l++) begin
    if (wValid[l]) begin
      n[wTag[l]] = 1'b1;  // Set beats clear
    end
  end
  return n;
endfunction

function automatic void recordWriteBack(input bypassPkt_t byp [NumLanes],
                                        input logic [NumLanes-1:0] bv, input logic rec);
  for (int l = 0; l < NumLanes; l++) begin
    if (bv[l] && !rec) begin
      shadowMem[byp[l].dest] = byp[l].data;
      written[byp[l].dest] = 1'b1;
    end
  end
endfunction

`endif

/* bench/regReadTb.sv */
// Testbench for the register-read stage
//   clock, reset and LFSR stimulus
//   directed cases for ready table, forwarding, recovery and squash
//   comparing process against the reference model
`timescale 1ns/10ps
`default_nettype none

module regReadTb;
  import regReadPkg::*;

  localparam int HalfPeriod = 20;

  logic                   clk;
  logic                   rstN;
  issuePkt_t              issuePkt [NumLanes];
  logic [NumLanes-1:0]    issueValid;
  bypassPkt_t             bypassPkt [NumLanes];
  logic [NumLanes-1:0]    bypassValid;
  unmapReq_t              unmap [NumLanes];
  physTag_t               wakeTag [NumLanes];
  logic [NumLanes-1:0]    wakeValid;
  ctrlResolve_t           ctrlResolve;
  logic                   recover;
  logic                   exception;
  execPkt_t               execPkt [NumLanes];
  logic [NumLanes-1:0]    execValid;
  logic [NumPhysRegs-1:0] physRegRdy;
  logic [15:0]            lfsrState;
  bit                     checkEn;

`include "regReadModel.svh"

  regRead dut_i (
    .clk           (clk),
    .rstN_i        (rstN),
    .issuePkt_i    (issuePkt),
    .issueValid_i  (issueValid),
    .bypassPkt_i   (bypassPkt),
    .bypassValid_i (bypassValid),
    .unmap_i       (unmap),
    .wakeTag_i     (wakeTag),
    .wakeValid_i   (wakeValid),
    .ctrlResolve_i (ctrlResolve),
    .recover_i     (recover),
    .exception_i   (exception),
    .execPkt_o     (execPkt),
    .execValid_o   (execValid),
    .physRegRdy_o  (physRegRdy)
  );

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  task automatic checkEq(input logic [255:0] got, input logic [255:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic waitReadyPattern(input int maxCycles, input string what);
    int n;
    n = 0;
    while (physRegRdy !== archReady() && n < maxCycles) begin
      @(negedge clk);
      n++;
    end
    if (physRegRdy !== archReady()) begin
      $display("ERROR: ready table never showed the architectural pattern %s", what);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  endtask

  task automatic clearInputs();
    for (int l = 0; l < NumLanes; l++) begin
      issuePkt[l] = '0;
      bypassPkt[l] = '0;
      unmap[l] = '0;
      wakeTag[l] = '0;
    end
    issueValid = '0;
    bypassValid = '0;
    wakeValid = '0;
    ctrlResolve = '0;
    recover = 1'b0;
    exception = 1'b0;
  endtask

  task automatic nextCycle();
    @(negedge clk);
    clearInputs();
  endtask

  // Usually a written register and now and then a bypass dest
  function automatic physTag_t pickSource();
    physTag_t t;
    int idx;
    if (randBits(2) == 0) begin
      idx = int'(randBits(1));
      return bypassPkt[idx].dest;
    end
    t = physTag_t'(randBits(PhysRegW));
    for (int i = 0; i < NumPhysRegs; i++) begin
      if (written[t]) begin
        return t;
      end
      t = t + physTag_t'(1);
    end
    return t;
  endfunction

  function automatic issuePkt_t randomIssue();
    issuePkt_t p;
    p.branchMask = NumCheckpoints'(randBits(NumCheckpoints));
    p.src1 = pickSource();
    p.src2 = pickSource();
    p.dest = physTag_t'(randBits(PhysRegW));
    p.opcode = opcode_t'(4'(randBits(8) % 5));
    p.imm = ImmW'(randBits(ImmW));
    p.pc = randBits(PcW);
    return p;
  endfunction

  task automatic randomCycle();
    for (int l = 0; l < NumLanes; l++) begin
      bypassValid[l] = 1'(randBits(1));
      bypassPkt[l].dest = physTag_t'(randBits(PhysRegW));
      bypassPkt[l].data = randBits(DataW);
      unmap[l].valid = 1'(randBits(1));
      unmap[l].tag = physTag_t'(randBits(PhysRegW));
      wakeValid[l] = 1'(randBits(1));
      wakeTag[l] = physTag_t'(randBits(PhysRegW));
    end
    recover = (randBits(3) == 0);
    exception = (randBits(5) == 0);
    ctrlResolve = ctrlResolve_t'(randBits(4));
    if (&bypassValid && !recover && bypassPkt[0].dest == bypassPkt[1].dest) begin
      bypassPkt[1].dest = bypassPkt[0].dest + physTag_t'(1);  // Keep writes to distinct tags
    end
    for (int l = 0; l < NumLanes; l++) begin
      issueValid[l] = 1'(randBits(1));
      issuePkt[l] = randomIssue();
    end
  endtask

  task automatic compareOutputs();
    logic [DataW-1:0] d;
    bit known;
    for (int l = 0; l < NumLanes; l++) begin
      checkEq(256'(execValid[l]),
              256'(survivesSquash(issueValid[l], issuePkt[l].branchMask, ctrlResolve)),
              $sformatf("lane %0d execValid", l));
      checkEq(256'(execPkt[l].issue), 256'(issuePkt[l]), $sformatf("lane %0d payload", l));
      known = forwardedOrStored(issuePkt[l].src1, bypassPkt, bypassValid, d);
      if (known) begin
        checkEq(256'(execPkt[l].src1Data), 256'(d), $sformatf("lane %0d src1Data", l));
      end
      known = forwardedOrStored(issuePkt[l].src2, bypassPkt, bypassValid, d);
      if (known) begin
        checkEq(256'(execPkt[l].src2Data), 256'(d), $sformatf("lane %0d src2Data", l));
      end
    end
    checkEq(256'(physRegRdy), 256'(shadowRdy), "ready table");
  endtask

  always @(posedge clk) begin
    recordWriteBack(bypassPkt, bypassValid, recover);
    shadowRdy = nextReady(shadowRdy, !rstN, exception, unmap, wakeTag, wakeValid);
  end

  // Outputs sampled 2 ns ahead of the rising edge
  always begin
    @(negedge clk);
    #(HalfPeriod - 2);
    if (checkEn) begin
      compareOutputs();
    end
  end

  initial begin
    logic [DataW-1:0] fwdData;
    logic [DataW-1:0] oldVal;
    lfsrState = 16'd43;
    checkEn = 1'b0;
    rstN = 1'b0;
    clearInputs();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    checkEn = 1'b1;
    waitReadyPattern(4, "after reset");

    // Fill every register through the write ports
    for (int t = 0; t < NumPhysRegs / NumLanes; t++) begin
      nextCycle();
      for (int l = 0; l < NumLanes; l++) begin
        bypassValid[l] = 1'b1;
        bypassPkt[l].dest = physTag_t'(NumLanes * t + l);
        bypassPkt[l].data = randBits(DataW);
      end
    end
    for (int t = 0; t < NumPhysRegs / NumLanes; t++) begin
      nextCycle();
      for (int l = 0; l < NumLanes; l++) begin
        issueValid[l] = 1'b1;
        issuePkt[l] = randomIssue();
        issuePkt[l].src1 = physTag_t'(NumLanes * t + l);
        issuePkt[l].src2 = physTag_t'(NumPhysRegs - 1 - NumLanes * t - l);
      end
    end

    // Unmap and wakeup with both on tag 20
    nextCycle();
    unmap[0] = '{valid: 1'b1, tag: physTag_t'(3)};
    unmap[1] = '{valid: 1'b1, tag: physTag_t'(20)};
    wakeValid = '1;
    wakeTag[0] = physTag_t'(20);
    wakeTag[1] = physTag_t'(25);
    nextCycle();
    checkEq(256'(physRegRdy[3]), 256'(1'b0), "unmapped tag 3");
    checkEq(256'(physRegRdy[20]), 256'(1'b1), "unmap and wake on tag 20");
    checkEq(256'(physRegRdy[25]), 256'(1'b1), "woken tag 25");
    exception = 1'b1;
    nextCycle();
    waitReadyPattern(3, "after exception");

    // Single-hit forwarding
    nextCycle();
    fwdData = randBits(DataW);
    bypassValid = '1;
    bypassPkt[0] = '{dest: physTag_t'(5), data: 32'hA5A5_0005};
    bypassPkt[1] = '{dest: physTag_t'(6), data: fwdData};
    issueValid = '1;
    issuePkt[0] = randomIssue();
    issuePkt[1] = randomIssue();
    issuePkt[0].src1 = physTag_t'(5);
    issuePkt[0].src2 = physTag_t'(6);
    issuePkt[1].src1 = physTag_t'(6);
    issuePkt[1].src2 = physTag_t'(7);
    #1;
    checkEq(256'(execPkt[0].src1Data), 256'(32'hA5A5_0005), "forward lane 0 to src1");
    checkEq(256'(execPkt[1].src1Data), 256'(fwdData), "forward lane 1 to src1");

    // Double hit falls back to the file; recovery keeps both writes out
    nextCycle();
    recover = 1'b1;
    bypassValid = '1;
    bypassPkt[0] = '{dest: physTag_t'(9), data: randBits(DataW)};
    bypassPkt[1] = '{dest: physTag_t'(9), data: randBits(DataW)};
    issueValid = '1;
    issuePkt[0].src1 = physTag_t'(9);
    issuePkt[1].src2 = physTag_t'(9);
    #1;
    checkEq(256'(execPkt[0].src1Data), 256'(shadowMem[9]), "double hit uses file");

    nextCycle();
    oldVal = shadowMem[12];
    recover = 1'b1;
    bypassValid[0] = 1'b1;
    bypassPkt[0] = '{dest: physTag_t'(12), data: 32'hDEAD_0012};
    nextCycle();
    issueValid[0] = 1'b1;
    issuePkt[0].src1 = physTag_t'(12);
    #1;
    checkEq(256'(execPkt[0].src1Data), 256'(oldVal), "write during recovery dropped");

    // Mispredict on checkpoint 2
    nextCycle();
    ctrlResolve = '{verified: 1'b1, mispredict: 1'b1, checkpointId: 2'd2};
    issueValid = '1;
    issuePkt[0] = randomIssue();
    issuePkt[1] = randomIssue();
    issuePkt[0].branchMask = 4'b0100;
    issuePkt[1].branchMask = 4'b1011;
    #1;
    checkEq(256'(execValid), 256'(2'b10), "squash of lane 0 only");
    nextCycle();
    ctrlResolve = '{verified: 1'b1, mispredict: 1'b0, checkpointId: 2'd2};
    issueValid = '1;
    issuePkt[0].branchMask = 4'b0100;
    #1;
    checkEq(256'(execValid), 256'(2'b11), "no squash on correct prediction");

    repeat (300) begin
      nextCycle();
      randomCycle();
    end
    nextCycle();
    @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+bench
rtl/regReadPkg.sv
rtl/physRegFile.sv
rtl/operandLane.sv
rtl/readyTable.sv
rtl/regRead.sv
bench/regReadTb.sv

/* Makefile */
# Verilator build and run of the register-read stage testbench

TOP := regReadTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
